/* logic/uart_string_pkg.sv */
// shared types and constants for the framed uart string link
// import with uart_string_pkg::* in the module header
`default_nettype none

package uart_string_pkg;

	// one character on the serial line
	typedef logic [7:0] char_t;

	// character count, 0 up to MAX_CHARS
	typedef logic [7:0] length_t;

	localparam int MAX_CHARS = 32;

	// character 0 sits in the lowest byte
	typedef logic [MAX_CHARS*8-1:0] string_t;

	typedef struct packed {
		string_t text;
		length_t length;
	} str_msg_t;

	// frame delimiter, sent twice at each end
	localparam char_t DELIM_CHAR = 8'h26;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_OPEN1,
		TX_OPEN2,
		TX_BODY,
		TX_CLOSE1,
		TX_CLOSE2,
		TX_FINISH
	} frame_tx_state_t;

	typedef enum logic [1:0] {
		RX_HUNT,
		RX_OPEN2,
		RX_BODY,
		RX_CLOSE2
	} frame_rx_state_t;

endpackage

`default_nettype wire

/* logic/uart_tx.sv */
// uart byte serializer, 8n1, lsb first
// byte_req is only accepted while idle; byte_done marks the end of the stop bit
`default_nettype none

module uart_tx import uart_string_pkg::*; #(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int BAUD_RATE = 115_200
) (
	input  wire   sys_clk,
	input  wire   sys_rst_n,
	input  char_t byte_data,
	input  wire   byte_req,
	output logic  byte_done,
	output logic  uart_tx_port
);

	localparam int BIT_CLKS = CLK_FREQ / BAUD_RATE;
	localparam int CNT_W    = $clog2(BIT_CLKS);

	typedef logic [CNT_W-1:0] bit_cnt_t;

	localparam bit_cnt_t CNT_LAST = bit_cnt_t'(BIT_CLKS - 1);

	logic       busy;
	bit_cnt_t   clk_cnt;
	logic [3:0] bit_idx;
	char_t      shift_q;
	logic       bit_end;

	assign bit_end = (clk_cnt == CNT_LAST);

	// last cycle of the stop bit
	assign byte_done = busy && bit_end && (bit_idx == 4'd9);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy         <= 1'b0;
			clk_cnt      <= '0;
			bit_idx      <= '0;
			uart_tx_port <= 1'b1;
		end else if (!busy) begin
			if (byte_req) begin
				busy         <= 1'b1;
				clk_cnt      <= '0;
				bit_idx      <= '0;
				// start bit goes out next cycle
				uart_tx_port <= 1'b0;
			end
		end else if (bit_end) begin
			clk_cnt <= '0;
			bit_idx <= bit_idx + 4'd1;
			if (bit_idx == 4'd9)
				busy <= 1'b0;
			else
				uart_tx_port <= shift_q[0];
		end else begin
			clk_cnt <= clk_cnt + bit_cnt_t'(1);
		end
	end

	// ones shift in behind the data, so the stop bit comes for free
	always_ff @(posedge sys_clk) begin
		if (!busy && byte_req)
			shift_q <= byte_data;
		else if (busy && bit_end && bit_idx != 4'd9)
			shift_q <= {1'b1, shift_q[7:1]};
	end

endmodule

`default_nettype wire

/* logic/uart_rx.sv */
// uart byte deserializer, 8n1, lsb first
// samples each bit in the middle after a two-flop synchronizer;
// rx_byte_vld pulses once per byte with a good stop bit
`default_nettype none

module uart_rx import uart_string_pkg::*; #(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int BAUD_RATE = 115_200
) (
	input  wire   sys_clk,
	input  wire   sys_rst_n,
	input  wire   uart_rx_port,
	output char_t rx_byte,
	output logic  rx_byte_vld
);

	localparam int BIT_CLKS = CLK_FREQ / BAUD_RATE;
	localparam int CNT_W    = $clog2(BIT_CLKS);

	typedef logic [CNT_W-1:0] bit_cnt_t;

	localparam bit_cnt_t CNT_LAST = bit_cnt_t'(BIT_CLKS - 1);
	localparam bit_cnt_t CNT_MID  = bit_cnt_t'(BIT_CLKS / 2 - 1);

	logic       rx_s1;
	logic       rx_s2;
	logic       rx_d;
	logic       fall;
	logic       busy;
	bit_cnt_t   clk_cnt;
	logic [3:0] bit_idx;
	char_t      shift_q;
	logic       mid;

	assign fall = rx_d && !rx_s2;
	assign mid  = busy && (clk_cnt == CNT_MID);

	// line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_s1 <= 1'b1;
			rx_s2 <= 1'b1;
			rx_d  <= 1'b1;
		end else begin
			rx_s1 <= uart_rx_port;
			rx_s2 <= rx_s1;
			rx_d  <= rx_s2;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy        <= 1'b0;
			clk_cnt     <= '0;
			bit_idx     <= '0;
			rx_byte_vld <= 1'b0;
		end else begin
			rx_byte_vld <= 1'b0;
			if (!busy) begin
				if (fall) begin
					busy    <= 1'b1;
					clk_cnt <= '0;
					bit_idx <= '0;
				end
			end else begin
				if (clk_cnt == CNT_LAST) begin
					clk_cnt <= '0;
					bit_idx <= bit_idx + 4'd1;
				end else begin
					clk_cnt <= clk_cnt + bit_cnt_t'(1);
				end
				// glitch on the start bit, back to idle
				if (mid && bit_idx == 4'd0 && rx_s2)
					busy <= 1'b0;
				// stop bit sampled, free again for the next start edge
				if (mid && bit_idx == 4'd9) begin
					busy        <= 1'b0;
					rx_byte_vld <= rx_s2;
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (mid && bit_idx >= 4'd1 && bit_idx <= 4'd8)
			shift_q <= {rx_s2, shift_q[7:1]};
		if (mid && bit_idx == 4'd9)
			rx_byte <= shift_q;
	end

endmodule

`default_nettype wire

/* logic/frame_tx.sv */
// transmit framer: sends "&&", the string content, then "&&" through uart_tx
// tx_req is taken only while tx_busy is low; tx_done pulses once per frame
`default_nettype none

module frame_tx import uart_string_pkg::*; (
	input  wire      sys_clk,
	input  wire      sys_rst_n,
	input  str_msg_t tx_msg,
	input  wire      tx_req,
	output logic     tx_busy,
	output logic     tx_done,
	output char_t    byte_data,
	output logic     byte_req,
	input  wire      byte_done
);

	frame_tx_state_t state;
	length_t         count;
	length_t         len_q;
	string_t         text_q;
	logic            accept;
	logic            send_char;

	assign accept  = (state == TX_IDLE) && tx_req;
	assign tx_busy = (state != TX_IDLE);
	assign tx_done = (state == TX_FINISH);

	// next byte is content rather than a delimiter
	assign send_char = ((state == TX_OPEN2) && (len_q != '0)) ||
	                   ((state == TX_BODY) && (count != len_q));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= TX_IDLE;
			count    <= '0;
			byte_req <= 1'b0;
		end else begin
			byte_req <= 1'b0;
			case (state)
				TX_IDLE: begin
					if (tx_req) begin
						state    <= TX_OPEN1;
						byte_req <= 1'b1;
					end
				end
				TX_OPEN1: begin
					if (byte_done) begin
						state    <= TX_OPEN2;
						byte_req <= 1'b1;
					end
				end
				TX_OPEN2: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						count    <= length_t'(1);
						// empty string goes straight to the closing pair
						state    <= send_char ? TX_BODY : TX_CLOSE1;
					end
				end
				TX_BODY: begin
					if (byte_done) begin
						byte_req <= 1'b1;
						if (send_char)
							count <= count + length_t'(1);
						else
							state <= TX_CLOSE1;
					end
				end
				TX_CLOSE1: begin
					if (byte_done) begin
						state    <= TX_CLOSE2;
						byte_req <= 1'b1;
					end
				end
				TX_CLOSE2: begin
					if (byte_done)
						state <= TX_FINISH;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// request is captured here, host may change tx_msg afterwards
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			text_q    <= tx_msg.text;
			len_q     <= (tx_msg.length > length_t'(MAX_CHARS)) ?
			             length_t'(MAX_CHARS) : tx_msg.length;
			byte_data <= DELIM_CHAR;
		end else if (byte_done) begin
			if (send_char) begin
				byte_data <= text_q[7:0];
				text_q    <= text_q >> 8;
			end else begin
				byte_data <= DELIM_CHAR;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/frame_rx.sv */
// receive framer: hunts for "&&", collects content up to the closing "&&"
// rx_msg updates only on rx_done; a bad or oversize frame pulses rx_error
`default_nettype none

module frame_rx import uart_string_pkg::*; (
	input  wire      sys_clk,
	input  wire      sys_rst_n,
	input  char_t    rx_byte,
	input  wire      rx_byte_vld,
	output str_msg_t rx_msg,
	output logic     rx_busy,
	output logic     rx_done,
	output logic     rx_error
);

	frame_rx_state_t state;
	length_t         wcount;
	string_t         work;
	logic            is_delim;

	assign is_delim = (rx_byte == DELIM_CHAR);
	assign rx_busy  = (state == RX_BODY) || (state == RX_CLOSE2);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= RX_HUNT;
			wcount   <= '0;
			rx_msg   <= '0;
			rx_done  <= 1'b0;
			rx_error <= 1'b0;
		end else begin
			rx_done  <= 1'b0;
			rx_error <= 1'b0;
			if (rx_byte_vld) begin
				case (state)
					RX_HUNT: begin
						if (is_delim)
							state <= RX_OPEN2;
					end
					RX_OPEN2: begin
						// lone '&' outside a frame is just noise
						state  <= is_delim ? RX_BODY : RX_HUNT;
						wcount <= '0;
					end
					RX_BODY: begin
						if (is_delim) begin
							state <= RX_CLOSE2;
						end else if (wcount == length_t'(MAX_CHARS)) begin
							state    <= RX_HUNT;
							rx_error <= 1'b1;
						end else begin
							wcount <= wcount + length_t'(1);
						end
					end
					RX_CLOSE2: begin
						state <= RX_HUNT;
						if (is_delim) begin
							rx_msg.text   <= work;
							rx_msg.length <= wcount;
							rx_done       <= 1'b1;
						end else begin
							rx_error <= 1'b1;
						end
					end
					default: state <= RX_HUNT;
				endcase
			end
		end
	end

	// working copy, cleared at frame start so unused bytes read zero
	always_ff @(posedge sys_clk) begin
		if (rx_byte_vld && state == RX_OPEN2 && is_delim)
			work <= '0;
		else if (rx_byte_vld && state == RX_BODY && !is_delim &&
		         wcount != length_t'(MAX_CHARS))
			work[{wcount[4:0], 3'b000} +: 8] <= rx_byte;
	end

endmodule

`default_nettype wire

/* logic/uart_string_link.sv */
// top level of the framed uart string link
// tx path: frame_tx -> uart_tx, rx path: uart_rx -> frame_rx
// CLK_FREQ and BAUD_RATE set the bit period of both serial blocks
`default_nettype none

module uart_string_link import uart_string_pkg::*; #(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int BAUD_RATE = 115_200
) (
	input  wire      sys_clk,
	input  wire      sys_rst_n,
	input  str_msg_t tx_msg,
	input  wire      tx_req,
	output logic     tx_busy,
	output logic     tx_done,
	output str_msg_t rx_msg,
	output logic     rx_busy,
	output logic     rx_done,
	output logic     rx_error,
	input  wire      uart_rx_port,
	output logic     uart_tx_port
);

	char_t byte_data;
	logic  byte_req;
	logic  byte_done;
	char_t rx_byte;
	logic  rx_byte_vld;

	frame_tx u_frame_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_msg    (tx_msg),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.byte_done (byte_done)
	);

	uart_tx #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD_RATE (BAUD_RATE)
	) u_uart_tx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.byte_data    (byte_data),
		.byte_req     (byte_req),
		.byte_done    (byte_done),
		.uart_tx_port (uart_tx_port)
	);

	uart_rx #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD_RATE (BAUD_RATE)
	) u_uart_rx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_port (uart_rx_port),
		.rx_byte      (rx_byte),
		.rx_byte_vld  (rx_byte_vld)
	);

	frame_rx u_frame_rx (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.rx_byte     (rx_byte),
		.rx_byte_vld (rx_byte_vld),
		.rx_msg      (rx_msg),
		.rx_busy     (rx_busy),
		.rx_done     (rx_done),
		.rx_error    (rx_error)
	);

endmodule

`default_nettype wire

/* test/tb_uart_string_link.sv */
// testbench for the framed uart string link
// loopback round trips, a tx line decoder, busy rules and receive errors
// on an injected line; assertions do all the checking
`default_nettype none

module tb_uart_string_link import uart_string_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_NS       = 40;
	localparam int BIT_CLKS     = 16;
	localparam int RESET_CLKS   = 16;
	localparam int SEED         = 40236;
	localparam int NUM_RANDOM   = 8;
	// random frames plus the one sent in the busy test
	localparam int NUM_FRAMES   = NUM_RANDOM + 1;
	localparam int BYTE_NS      = 10 * BIT_CLKS * CLK_NS;
	localparam int FRAME_NS_MAX = (MAX_CHARS + 4) * BYTE_NS + (MAX_CHARS + 6) * CLK_NS;
	localparam int TX_WAIT_CLKS = FRAME_NS_MAX / CLK_NS + 10;
	localparam int RESULT_CLKS  = 2 * BIT_CLKS;
	// noise frame 10, bad close 6, oversize 35, empty frame 4
	localparam int INJECT_BYTES = 55;
	localparam int INJECT_OK    = 2;
	localparam int WATCHDOG_NS  = ((NUM_FRAMES * FRAME_NS_MAX + INJECT_BYTES * BYTE_NS +
	                              RESET_CLKS * CLK_NS) * 12) / 10;

	logic     sys_clk;
	logic     sys_rst_n;
	str_msg_t tx_msg;
	logic     tx_req;
	logic     tx_busy;
	logic     tx_done;
	str_msg_t rx_msg;
	logic     rx_busy;
	logic     rx_done;
	logic     rx_error;
	logic     uart_rx_port;
	logic     uart_tx_port;
	logic     line_sel;
	logic     inj_line;

	int       errors;
	int       accepted_cnt;
	int       tx_done_cnt;
	int       rx_done_cnt;
	int       rx_err_cnt;
	str_msg_t rx_expect_q[$];
	char_t    line_q[$];

	// loopback when line_sel is high, otherwise the injected line
	assign uart_rx_port = line_sel ? uart_tx_port : inj_line;

	uart_string_link #(
		.CLK_FREQ  (25_000_000),
		.BAUD_RATE (1_562_500)
	) u_uart_string_link (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_msg       (tx_msg),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_msg       (rx_msg),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_error     (rx_error),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_NS / 2) sys_clk = ~sys_clk;
	end

	task automatic flag_mismatch(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic note_problem(input string msg);
		$display("problem at %0t ns: %s", $time, msg);
		errors++;
	endtask

	// received text holds zeros above the length
	function automatic str_msg_t clear_unused(input str_msg_t m);
		str_msg_t r;
		r = '0;
		r.length = m.length;
		for (int i = 0; i < MAX_CHARS; i++)
			if (i < int'(m.length))
				r.text[i*8 +: 8] = m.text[i*8 +: 8];
		return r;
	endfunction

	function automatic str_msg_t make_msg(input string s);
		str_msg_t r;
		r = '0;
		r.length = length_t'(s.len());
		for (int i = 0; i < s.len(); i++)
			r.text[i*8 +: 8] = char_t'(s[i]);
		return r;
	endfunction

	// printable content without '&' and garbage above the length
	function automatic str_msg_t random_msg(input int len);
		str_msg_t m;
		char_t    c;
		m.length = length_t'(len);
		for (int i = 0; i < MAX_CHARS; i++) begin
			if (i < len) begin
				do c = char_t'($urandom_range(8'h7e, 8'h21));
				while (c == DELIM_CHAR);
			end else begin
				c = char_t'($urandom_range(255, 0));
			end
			m.text[i*8 +: 8] = c;
		end
		return m;
	endfunction

	task automatic check_idle_outputs(input string when_s);
		assert (uart_tx_port === 1'b1 && tx_busy === 1'b0 && tx_done === 1'b0 &&
		        rx_busy === 1'b0 && rx_done === 1'b0 && rx_error === 1'b0 &&
		        rx_msg === '0)
		else flag_mismatch($sformatf("outputs not idle %s", when_s));
	endtask

	task automatic send_msg(input str_msg_t m);
		@(posedge sys_clk);
		tx_msg <= m;
		tx_req <= 1'b1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
	endtask

	task automatic wait_tx_done();
		int n;
		n = 0;
		do begin
			@(posedge sys_clk);
			n++;
		end while (!tx_done && n < TX_WAIT_CLKS);
		if (!tx_done)
			note_problem("tx_done never came for the last request");
	endtask

	task automatic drive_bit(input logic v);
		@(posedge sys_clk);
		inj_line <= v;
		repeat (BIT_CLKS - 1) @(posedge sys_clk);
	endtask

	task automatic inject_byte(input char_t b);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++)
			drive_bit(b[i]);
		drive_bit(1'b1);
	endtask

	// sends s on the injected line, then waits for rx_done or rx_error
	task automatic run_injection(input string s, input int exp_done, input int exp_err);
		int done_before;
		int err_before;
		int n;
		done_before = rx_done_cnt;
		err_before  = rx_err_cnt;
		for (int i = 0; i < s.len(); i++)
			inject_byte(char_t'(s[i]));
		n = 0;
		while (rx_done_cnt + rx_err_cnt == done_before + err_before && n < RESULT_CLKS) begin
			@(posedge sys_clk);
			n++;
		end
		if (n == RESULT_CLKS)
			note_problem($sformatf("no rx_done or rx_error after \"%s\"", s));
		else
			assert (rx_done_cnt - done_before == exp_done && rx_err_cnt - err_before == exp_err)
			else flag_mismatch($sformatf("\"%s\" gave %0d rx_done and %0d rx_error",
			                             s, rx_done_cnt - done_before, rx_err_cnt - err_before));
	endtask

	// every accepted request yields one expected frame on the line and at rx
	always @(posedge sys_clk) begin : request_monitor
		str_msg_t m;
		if (sys_rst_n && tx_req && !tx_busy) begin
			m = clear_unused(tx_msg);
			rx_expect_q.push_back(m);
			line_q.push_back(DELIM_CHAR);
			line_q.push_back(DELIM_CHAR);
			for (int i = 0; i < int'(m.length); i++)
				line_q.push_back(m.text[i*8 +: 8]);
			line_q.push_back(DELIM_CHAR);
			line_q.push_back(DELIM_CHAR);
			accepted_cnt <= accepted_cnt + 1;
		end
		if (sys_rst_n && tx_done)
			tx_done_cnt <= tx_done_cnt + 1;
	end

	always @(posedge sys_clk) begin : rx_monitor
		str_msg_t exp_m;
		if (sys_rst_n && rx_done) begin
			rx_done_cnt <= rx_done_cnt + 1;
			if (rx_expect_q.size() == 0) begin
				note_problem("rx_done without any frame sent");
			end else begin
				exp_m = rx_expect_q.pop_front();
				assert (rx_msg == exp_m)
				else flag_mismatch($sformatf("rx_msg len %0d text %h, expected len %0d text %h",
				                             rx_msg.length, rx_msg.text, exp_m.length, exp_m.text));
			end
		end
		if (sys_rst_n && rx_error)
			rx_err_cnt <= rx_err_cnt + 1;
	end

	// independent decode of uart_tx_port, sampled mid-bit
	always begin : line_decoder
		char_t b;
		char_t exp_b;
		@(posedge sys_clk);
		if (sys_rst_n && !uart_tx_port) begin
			repeat (BIT_CLKS / 2) @(posedge sys_clk);
			assert (!uart_tx_port) else flag_mismatch("start bit high at its middle");
			for (int i = 0; i < 8; i++) begin
				repeat (BIT_CLKS) @(posedge sys_clk);
				b[i] = uart_tx_port;
			end
			repeat (BIT_CLKS) @(posedge sys_clk);
			assert (uart_tx_port) else flag_mismatch("stop bit low on uart_tx_port");
			if (line_q.size() == 0) begin
				note_problem($sformatf("byte %h on the line with no frame sent", b));
			end else begin
				exp_b = line_q.pop_front();
				assert (b == exp_b)
				else flag_mismatch($sformatf("line byte %h, expected %h", b, exp_b));
			end
		end
	end

	tx_done_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |=> !tx_done)
		else flag_mismatch("tx_done high for more than one cycle");
	busy_rise: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_req && !tx_busy |=> tx_busy)
		else flag_mismatch("tx_busy did not rise after an accepted tx_req");
	busy_hold: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_busy && !tx_done |=> tx_busy)
		else flag_mismatch("tx_busy fell before tx_done");
	busy_at_done: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |-> tx_busy)
		else flag_mismatch("tx_busy low during tx_done");
	busy_fall: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |=> !tx_busy)
		else flag_mismatch("tx_busy still high the cycle after tx_done");
	no_spurious_start: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx_busy && !tx_req |=> !tx_busy)
		else flag_mismatch("tx_busy rose without a request");
	line_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx_busy |-> uart_tx_port)
		else flag_mismatch("uart_tx_port low between frames");
	rx_pulses: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(rx_done || rx_error) |-> !rx_busy)
		else flag_mismatch("rx_busy high with rx_done or rx_error");
	rx_busy_frame: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(rx_done || rx_error) |-> $past(rx_busy))
		else flag_mismatch("rx_busy low in the cycle before rx_done or rx_error");
	rx_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(rx_done || rx_error) |=> !(rx_done || rx_error))
		else flag_mismatch("rx_done or rx_error longer than one cycle");

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout: run still going after %0d ns, %0d errors so far", WATCHDOG_NS, errors);
		$display("Finished with errors");
		$finish;
	end

	initial begin : stimulus
		str_msg_t prev;
		string    s;
		int       len;
		errors       = 0;
		accepted_cnt = 0;
		tx_done_cnt  = 0;
		rx_done_cnt  = 0;
		rx_err_cnt   = 0;
		sys_rst_n    = 1'b0;
		tx_req       = 1'b0;
		tx_msg       = '0;
		line_sel     = 1'b1;
		inj_line     = 1'b1;
		void'($urandom(SEED));

		repeat (RESET_CLKS - 1) @(posedge sys_clk);
		check_idle_outputs("during reset");
		@(posedge sys_clk);
		sys_rst_n <= 1'b1;
		repeat (2) @(posedge sys_clk);
		check_idle_outputs("after reset");

		// loopback with the full and empty strings first
		for (int i = 0; i < NUM_RANDOM; i++) begin
			if (i == 0)
				len = MAX_CHARS;
			else if (i == 1)
				len = 0;
			else
				len = $urandom_range(MAX_CHARS, 0);
			send_msg(random_msg(len));
			wait_tx_done();
		end

		// second request lands while busy and must be dropped
		send_msg(random_msg(5));
		repeat (2 * BIT_CLKS) @(posedge sys_clk);
		assert (tx_busy) else flag_mismatch("tx_busy low in the middle of a frame");
		tx_msg <= random_msg(7);
		tx_req <= 1'b1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
		wait_tx_done();
		repeat (3) @(posedge sys_clk);
		assert (!tx_busy) else flag_mismatch("a request made while busy started a frame");

		// injected line
		line_sel <= 1'b0;
		rx_expect_q.push_back(make_msg("abc"));
		run_injection("x&q&&abc&&", 1, 0);
		prev = rx_msg;
		run_injection("&&ab&x", 0, 1);
		assert (rx_msg == prev) else flag_mismatch("rx_msg changed after a framing error");
		s = "&&";
		repeat (MAX_CHARS + 1) s = {s, "k"};
		run_injection(s, 0, 1);
		rx_expect_q.push_back(make_msg(""));
		run_injection("&&&&", 1, 0);
		repeat (2) @(posedge sys_clk);

		assert (rx_expect_q.size() == 0)
		else note_problem($sformatf("%0d frames never received", rx_expect_q.size()));
		assert (line_q.size() == 0)
		else note_problem($sformatf("%0d bytes never seen on the line", line_q.size()));
		assert (accepted_cnt == NUM_FRAMES)
		else flag_mismatch($sformatf("%0d requests accepted, expected %0d",
		                             accepted_cnt, NUM_FRAMES));
		assert (tx_done_cnt == NUM_FRAMES)
		else flag_mismatch($sformatf("%0d tx_done for %0d requests", tx_done_cnt, NUM_FRAMES));
		assert (rx_done_cnt == NUM_FRAMES + INJECT_OK)
		else flag_mismatch($sformatf("%0d rx_done, expected %0d",
		                             rx_done_cnt, NUM_FRAMES + INJECT_OK));

		$display("%0d errors, %0d requests, %0d tx_done, %0d rx_done, %0d rx_error",
		         errors, accepted_cnt, tx_done_cnt, rx_done_cnt, rx_err_cnt);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

/* uart_string_link.f */
logic/uart_string_pkg.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/frame_tx.sv
logic/frame_rx.sv
logic/uart_string_link.sv
test/tb_uart_string_link.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_uart_string_link
FILELIST  := uart_string_link.f
OBJ_DIR   := obj_dir
FLAGS     := --timing --assert --timescale 1ns/100ps
PASS_MSG  := Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
